// ==== verification/kinpira_golden.txt ====
# test op addr(hex) data(hex) arg(dec)
# W write, R read expect, S start, P poll done expect, B busy read expect with min stall
1 W 0002 00000abc 0
1 W 0003 00000123 0
1 W 0004 000007ff 0
1 W 0005 000003ff 0
1 W 0006 00000155 0
1 W 0007 0000ffff 0
1 R 0002 00000abc 0
1 R 0003 00000123 0
1 R 0004 000007ff 0
1 R 0005 000003ff 0
1 R 0006 00000155 0
1 R 0007 00000000 0
1 R 0100 00000000 0
2 W 4100 00008001 0
2 W 8100 0000fffe 0
2 R 4100 ffff8001 0
2 R 8100 fffffffe 0
3 W 4010 00000100 0
3 W 4011 00000200 0
3 W 4012 0000ff00 0
3 W 4013 00000080 0
3 W 8000 00000100 0
3 W 8001 00000100 0
3 W 8002 00000080 0
3 W 8003 00000100 0
3 W 8004 00000040 0
3 W 8005 0000ff00 0
3 W 8006 0000ff00 0
3 W 8007 00000000 0
3 W 8008 00000000 0
3 W 8009 00000010 0
3 W 800a 00007fff 0
3 W 800b 00007fff 0
3 W 800c 00000000 0
3 W 800d 00000000 0
3 W 800e 00000000 0
3 W 0002 00000010 0
3 W 0003 00000020 0
3 W 0004 00000000 0
3 W 0005 00000004 0
3 W 0006 00000003 0
3 S 0000 00000001 0
3 P 0001 00000002 0
3 R 4020 00000340 0
4 R 4021 00000000 0
4 R 4022 00007fff 0
5 W 4018 00000080 0
5 W 4019 00000000 0
5 W 401a 00000000 0
5 W 401b 00000000 0
5 W 0002 00000018 0
5 W 0003 00000030 0
5 S 0000 00000001 0
5 R 0001 00000001 0
5 B 4010 00000100 10
5 R 0001 00000002 0
6 P 0001 00000002 0
6 R 4030 000000c0 0
6 R 4031 00000000 0
6 R 4032 00003fff 0
6 R 4020 00000340 0
6 R 4021 00000000 0
6 R 4022 00007fff 0

// ==== filelist.f ====
src/kinpira_pkg.sv
src/mem_sp.sv
src/ninjin_bus.sv
src/gobou_core.sv
src/gobou_activate.sv
src/kinpira_top.sv
verification/kinpira_props.sv
verification/kinpira_tb.sv

// ==== Bender.yml ====
package:
  name: kinpira

sources:
  - src/kinpira_pkg.sv
  - src/mem_sp.sv
  - src/ninjin_bus.sv
  - src/gobou_core.sv
  - src/gobou_activate.sv
  - src/kinpira_top.sv
  - target: test
    files:
      - verification/kinpira_props.sv
      - verification/kinpira_tb.sv

// ==== verification/kinpira_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module kinpira_tb
  import kinpira_pkg::*;
();

  localparam int max_rec     = 256;
  localparam int cyc_per_rec = 200;
  // Two layers of 3 outputs with 4 inputs each
  localparam int layer_bound = 2 * 3 * (4 + 4);

  logic    clk;
  logic    xrst;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;

  int          rec_test [max_rec];
  logic [7:0]  rec_op   [max_rec];
  logic [15:0] rec_adr  [max_rec];
  logic [31:0] rec_dat  [max_rec];
  int          rec_arg  [max_rec];
  int          n_rec;
  int          errors;
  int          checks;
  int          tests;
  logic        loaded;

  kinpira_top kinpira_top_i (
    .clk    (clk),
    .xrst   (xrst),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    wait (loaded);
    repeat (n_rec * cyc_per_rec + layer_bound) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles",
             n_rec * cyc_per_rec + layer_bound);
    $display("FAIL: see errors above");
    $finish;
  end

  task automatic load_golden();
    int               fd;
    int               r;
    int               num;
    logic [7:0]       op;
    logic [15:0]      adr;
    logic [31:0]      dat;
    int               arg;
    logic [8*128-1:0] line;
    n_rec = 0;
    fd = $fopen("verification/kinpira_golden.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open verification/kinpira_golden.txt for reading");
    end else begin
      r = 0;
      while (r != -1 && n_rec < max_rec) begin
        r = $fscanf(fd, "%d %s %h %h %d\n", num, op, adr, dat, arg);
        if (r == 5) begin
          rec_test[n_rec] = num;
          rec_op[n_rec]   = op;
          rec_adr[n_rec]  = adr;
          rec_dat[n_rec]  = dat;
          rec_arg[n_rec]  = arg;
          n_rec++;
        end else if (r != -1) begin
          // Comment line
          r = $fgets(line, fd);
        end
      end
      $fclose(fd);
      if (n_rec == 0) begin
        errors++;
        $display("The golden file holds no records");
      end
    end
  endtask

  task automatic wb_access(input logic we, input logic [15:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat, output int waits);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    waits = 0;
    @(posedge clk);
    #1;
    while (!wb_rsp.ack) begin
      waits++;
      @(posedge clk);
      #1;
    end
    rdat = wb_rsp.dat;
    // Release one edge after ack is seen, then one idle cycle
    @(posedge clk);
    #1;
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic run_record(input int i);
    logic [31:0] rdat;
    int          waits;
    case (rec_op[i])
      "W": wb_access(1'b1, rec_adr[i], rec_dat[i], rdat, waits);
      "S": wb_access(1'b1, {REGION_REG, 14'(REG_CTRL)}, 32'd1, rdat, waits);
      "R": begin
        wb_access(1'b0, rec_adr[i], '0, rdat, waits);
        checks++;
        if (rdat !== rec_dat[i]) begin
          errors++;
          $display("Fail %0t: read of %h gave %h, expected %h",
                   $time, rec_adr[i], rdat, rec_dat[i]);
        end
      end
      "P": begin
        rdat = '0;
        while (rdat[1] !== 1'b1) begin
          wb_access(1'b0, {REGION_REG, 14'(REG_STATUS)}, '0, rdat, waits);
        end
        checks++;
        if (rdat !== rec_dat[i]) begin
          errors++;
          $display("Fail %0t: status %h after done, expected %h", $time, rdat, rec_dat[i]);
        end
      end
      "B": begin
        wb_access(1'b0, rec_adr[i], '0, rdat, waits);
        checks++;
        if (rdat !== rec_dat[i]) begin
          errors++;
          $display("Fail %0t: stalled read of %h gave %h, expected %h",
                   $time, rec_adr[i], rdat, rec_dat[i]);
        end
        checks++;
        if (waits < rec_arg[i]) begin
          errors++;
          $display("Fail %0t: access stalled %0d cycles, expected at least %0d",
                   $time, waits, rec_arg[i]);
        end
      end
      default: begin
        errors++;
        $display("Unknown operation %s in golden record %0d", rec_op[i], i);
      end
    endcase
  endtask

  initial begin
    int cur;
    int base;
    loaded = 1'b0;
    errors = 0;
    checks = 0;
    tests  = 0;
    wb_req = '0;
    xrst   = 1'b0;
    load_golden();
    loaded = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    xrst = 1'b1;
    cur  = n_rec > 0 ? rec_test[0] : 0;
    base = errors;
    for (int i = 0; i < n_rec; i++) begin
      if (rec_test[i] != cur) begin
        tests++;
        $display("Test %0d done, %0d errors", cur, errors - base);
        cur  = rec_test[i];
        base = errors;
      end
      run_record(i);
    end
    if (n_rec > 0) begin
      tests++;
      $display("Test %0d done, %0d errors", cur, errors - base);
    end
    // Assertion failures from the bound checker
    errors += kinpira_top_i.ninjin_bus_i.kinpira_props_i.fail_cnt;
    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/kinpira_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module kinpira_props
  import kinpira_pkg::*;
(
  input logic     clk,
  input logic     xrst,
  input wb_req_t  wb_req,
  input wb_rsp_t  wb_rsp,
  input logic     start,
  input logic     busy,
  input logic     done,
  input img_req_t eng_img_wr
);

  int fail_cnt = 0;

  ack_needs_req: assert property (@(posedge clk) disable iff (!xrst)
    wb_rsp.ack |-> wb_req.cyc && wb_req.stb)
    else begin
      fail_cnt++;
      $error("ack without cyc and stb");
    end

  ack_one_cycle: assert property (@(posedge clk) disable iff (!xrst)
    wb_rsp.ack |=> !wb_rsp.ack)
    else begin
      fail_cnt++;
      $error("ack held for two cycles");
    end

  start_when_idle: assert property (@(posedge clk) disable iff (!xrst)
    start |-> !busy)
    else begin
      fail_cnt++;
      $error("start while the engine is busy");
    end

  // Engine writes and done only inside a run
  engine_in_run: assert property (@(posedge clk) disable iff (!xrst)
    (eng_img_wr.we || done) |-> busy)
    else begin
      fail_cnt++;
      $error("engine activity while not busy");
    end

endmodule

bind ninjin_bus kinpira_props kinpira_props_i (
  .clk        (clk),
  .xrst       (xrst),
  .wb_req     (wb_req),
  .wb_rsp     (wb_rsp),
  .start      (start),
  .busy       (busy),
  .done       (done),
  .eng_img_wr (eng_img_wr)
);

`default_nettype wire

// ==== src/kinpira_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module kinpira_top
  import kinpira_pkg::*;
(
  input  logic    clk,
  input  logic    xrst,
  input  wb_req_t wb_req,
  output wb_rsp_t wb_rsp
);

  logic                       start;
  logic                       done;
  layer_cfg_t                 cfg;
  img_req_t                   img_port;
  net_req_t                   net_port;
  img_req_t                   eng_img_rd;
  net_req_t                   eng_net_rd;
  img_req_t                   eng_img_wr;
  logic [DWIDTH-1:0]          img_rdata;
  logic [DWIDTH-1:0]          net_rdata;
  logic signed [ACCWIDTH-1:0] acc;
  logic signed [DWIDTH-1:0]   bias;
  logic                       acc_valid;

  ninjin_bus ninjin_bus_i (
    .clk        (clk),
    .xrst       (xrst),
    .wb_req     (wb_req),
    .img_rdata  (img_rdata),
    .net_rdata  (net_rdata),
    .done       (done),
    .eng_img_rd (eng_img_rd),
    .eng_net_rd (eng_net_rd),
    .eng_img_wr (eng_img_wr),
    .wb_rsp     (wb_rsp),
    .start      (start),
    .cfg        (cfg),
    .img_port   (img_port),
    .net_port   (net_port)
  );

  mem_sp #(
    .DEPTH_LOG (IMGSIZE),
    .WIDTH     (DWIDTH)
  ) img_mem (
    .clk   (clk),
    .we    (img_port.we),
    .addr  (img_port.addr),
    .wdata (img_port.wdata),
    .rdata (img_rdata)
  );

  mem_sp #(
    .DEPTH_LOG (NETSIZE),
    .WIDTH     (DWIDTH)
  ) net_mem (
    .clk   (clk),
    .we    (net_port.we),
    .addr  (net_port.addr),
    .wdata (net_port.wdata),
    .rdata (net_rdata)
  );

  gobou_core gobou_core_i (
    .clk       (clk),
    .xrst      (xrst),
    .start     (start),
    .cfg       (cfg),
    .img_rdata (img_rdata),
    .net_rdata (net_rdata),
    .img_rd    (eng_img_rd),
    .net_rd    (eng_net_rd),
    .acc       (acc),
    .bias      (bias),
    .acc_valid (acc_valid),
    .done      (done)
  );

  gobou_activate gobou_activate_i (
    .clk        (clk),
    .xrst       (xrst),
    .acc        (acc),
    .bias       (bias),
    .acc_valid  (acc_valid),
    .out_offset (cfg.out_offset),
    .img_wr     (eng_img_wr)
  );

endmodule

`default_nettype wire

// ==== src/gobou_activate.sv ====
`timescale 1ns/10ps
`default_nettype none

module gobou_activate
  import kinpira_pkg::*;
(
  input  logic                       clk,
  input  logic                       xrst,
  input  logic signed [ACCWIDTH-1:0] acc,
  input  logic signed [DWIDTH-1:0]   bias,
  input  logic                       acc_valid,
  input  logic [IMGSIZE-1:0]         out_offset,
  output img_req_t                   img_wr
);

  localparam logic signed [ACCWIDTH-1:0] sat_max = ACCWIDTH'((1 << (DWIDTH-1)) - 1);

  logic signed [ACCWIDTH-1:0] sum;
  logic [DWIDTH-1:0]          result;
  logic [LWIDTH-1:0]          out_cnt;
  logic [IMGSIZE-1:0]         base;
  logic                       new_layer;
  logic                       wr_we;
  logic [IMGSIZE-1:0]         wr_addr;
  logic [DWIDTH-1:0]          wr_data;

  assign sum = (acc >>> FRACBITS) + ACCWIDTH'(bias);

  // ReLU, then clamp to the largest positive word
  always_comb begin
    if (sum[ACCWIDTH-1]) begin
      result = '0;
    end else if (sum > sat_max) begin
      result = sat_max[DWIDTH-1:0];
    end else begin
      result = sum[DWIDTH-1:0];
    end
  end

  // A layer with another output offset starts counting again
  assign new_layer = out_offset != base;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      wr_we   <= 1'b0;
      out_cnt <= '0;
      base    <= '0;
    end else begin
      wr_we <= acc_valid;
      if (acc_valid) begin
        base    <= out_offset;
        out_cnt <= new_layer ? LWIDTH'(1) : out_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (acc_valid) begin
      wr_addr <= new_layer ? out_offset : out_offset + IMGSIZE'(out_cnt);
      wr_data <= result;
    end
  end

  assign img_wr = '{we: wr_we, addr: wr_addr, wdata: wr_data};

endmodule

`default_nettype wire

// ==== src/gobou_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module gobou_core
  import kinpira_pkg::*;
(
  input  logic                       clk,
  input  logic                       xrst,
  input  logic                       start,
  input  layer_cfg_t                 cfg,
  input  logic signed [DWIDTH-1:0]   img_rdata,
  input  logic signed [DWIDTH-1:0]   net_rdata,
  output img_req_t                   img_rd,
  output net_req_t                   net_rd,
  output logic signed [ACCWIDTH-1:0] acc,
  output logic signed [DWIDTH-1:0]   bias,
  output logic                       acc_valid,
  output logic                       done
);

  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_drain,
    st_writeback
  } state_t;

  state_t                     state;
  logic [LWIDTH-1:0]          in_cnt;
  logic [LWIDTH-1:0]          out_cnt;
  logic [NETSIZE-1:0]         wptr;
  logic                       mac_en;
  logic                       bias_en;
  logic                       wb_second;
  logic                       last_in;
  logic                       last_out;
  logic                       acc_clear;
  logic signed [2*DWIDTH-1:0] product;

  // Index total_in is the bias slot
  assign last_in   = in_cnt == cfg.total_in;
  assign last_out  = out_cnt + 1'b1 == cfg.total_out;
  assign acc_clear = (state == st_idle && start) || (state == st_writeback && wb_second);
  assign product   = img_rdata * net_rdata;

  assign img_rd = '{we: 1'b0, addr: cfg.in_offset + IMGSIZE'(in_cnt), wdata: '0};
  assign net_rd = '{we: 1'b0, addr: wptr, wdata: '0};

  assign acc_valid = state == st_writeback && !wb_second;
  // Second writeback cycle is when gobou_activate writes
  assign done      = state == st_writeback && wb_second && last_out;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state     <= st_idle;
      in_cnt    <= '0;
      out_cnt   <= '0;
      wptr      <= '0;
      mac_en    <= 1'b0;
      bias_en   <= 1'b0;
      wb_second <= 1'b0;
    end else begin
      mac_en  <= state == st_read && !last_in;
      bias_en <= state == st_read && last_in;
      case (state)
        st_idle: begin
          if (start) begin
            state   <= st_read;
            in_cnt  <= '0;
            out_cnt <= '0;
            wptr    <= cfg.net_offset;
          end
        end
        st_read: begin
          wptr <= wptr + 1'b1;
          if (last_in) begin
            state <= st_drain;
          end else begin
            in_cnt <= in_cnt + 1'b1;
          end
        end
        st_drain: state <= st_writeback;
        st_writeback: begin
          wb_second <= !wb_second;
          if (wb_second) begin
            in_cnt  <= '0;
            out_cnt <= out_cnt + 1'b1;
            state   <= last_out ? st_idle : st_read;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // MAC runs one cycle behind its read
  always_ff @(posedge clk) begin
    if (acc_clear) begin
      acc <= '0;
    end else if (mac_en) begin
      acc <= acc + ACCWIDTH'(product);
    end
    if (bias_en) begin
      bias <= net_rdata;
    end
  end

endmodule

`default_nettype wire

// ==== src/ninjin_bus.sv ====
`timescale 1ns/10ps
`default_nettype none

module ninjin_bus
  import kinpira_pkg::*;
(
  input  logic              clk,
  input  logic              xrst,
  input  wb_req_t           wb_req,
  input  logic [DWIDTH-1:0] img_rdata,
  input  logic [DWIDTH-1:0] net_rdata,
  input  logic              done,
  input  img_req_t          eng_img_rd,
  input  net_req_t          eng_net_rd,
  input  img_req_t          eng_img_wr,
  output wb_rsp_t           wb_rsp,
  output logic              start,
  output layer_cfg_t        cfg,
  output img_req_t          img_port,
  output net_req_t          net_port
);

  logic                 busy;
  logic                 done_flag;
  logic                 rd_pend;
  logic                 rd_img;
  logic [1:0]           region;
  logic [13:0]          reg_idx;
  logic                 is_reg;
  logic                 is_img;
  logic                 is_net;
  logic                 req_new;
  logic                 accept;
  logic [WB_DWIDTH-1:0] reg_rdata;
  img_req_t             host_img;
  net_req_t             host_net;

  assign region  = wb_req.adr[15:14];
  assign reg_idx = wb_req.adr[13:0];
  assign is_reg  = region == REGION_REG;
  assign is_img  = region == REGION_IMG;
  assign is_net  = region == REGION_NET;

  // New request, not yet answered and no read in flight
  assign req_new = wb_req.cyc && wb_req.stb && !wb_rsp.ack && !rd_pend;
  // Memory regions wait for the engine to finish
  assign accept  = req_new && !(busy && (is_img || is_net));

  always_comb begin
    case (reg_idx)
      REG_STATUS:     reg_rdata = WB_DWIDTH'({done_flag, busy});
      REG_IN_OFFSET:  reg_rdata = WB_DWIDTH'(cfg.in_offset);
      REG_OUT_OFFSET: reg_rdata = WB_DWIDTH'(cfg.out_offset);
      REG_NET_OFFSET: reg_rdata = WB_DWIDTH'(cfg.net_offset);
      REG_TOTAL_IN:   reg_rdata = WB_DWIDTH'(cfg.total_in);
      REG_TOTAL_OUT:  reg_rdata = WB_DWIDTH'(cfg.total_out);
      default:        reg_rdata = '0;
    endcase
  end

  assign host_img = '{we:    accept && is_img && wb_req.we,
                      addr:  wb_req.adr[IMGSIZE-1:0],
                      wdata: wb_req.dat[DWIDTH-1:0]};
  assign host_net = '{we:    accept && is_net && wb_req.we,
                      addr:  wb_req.adr[NETSIZE-1:0],
                      wdata: wb_req.dat[DWIDTH-1:0]};

  // Engine reads and writes never overlap on the image port
  always_comb begin
    if (busy) begin
      img_port = eng_img_wr.we ? eng_img_wr : eng_img_rd;
      net_port = eng_net_rd;
    end else begin
      img_port = host_img;
      net_port = host_net;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      wb_rsp.ack <= 1'b0;
      rd_pend    <= 1'b0;
      start      <= 1'b0;
      busy       <= 1'b0;
      done_flag  <= 1'b0;
      cfg        <= '0;
    end else begin
      wb_rsp.ack <= 1'b0;
      start      <= 1'b0;
      if (rd_pend) begin
        rd_pend    <= 1'b0;
        wb_rsp.ack <= 1'b1;
        wb_rsp.dat <= rd_img ? WB_DWIDTH'(signed'(img_rdata))
                             : WB_DWIDTH'(signed'(net_rdata));
      end else if (accept) begin
        if ((is_img || is_net) && !wb_req.we) begin
          rd_pend <= 1'b1;
          rd_img  <= is_img;
        end else begin
          wb_rsp.ack <= 1'b1;
          wb_rsp.dat <= is_reg ? reg_rdata : '0;
          // Layer setup frozen while the engine runs
          if (is_reg && wb_req.we && !busy && !start) begin
            case (reg_idx)
              REG_CTRL:       start          <= wb_req.dat[0];
              REG_IN_OFFSET:  cfg.in_offset  <= wb_req.dat[IMGSIZE-1:0];
              REG_OUT_OFFSET: cfg.out_offset <= wb_req.dat[IMGSIZE-1:0];
              REG_NET_OFFSET: cfg.net_offset <= wb_req.dat[NETSIZE-1:0];
              REG_TOTAL_IN:   cfg.total_in   <= wb_req.dat[LWIDTH-1:0];
              REG_TOTAL_OUT:  cfg.total_out  <= wb_req.dat[LWIDTH-1:0];
              default:        ;
            endcase
          end
        end
      end
      if (start) begin
        busy      <= 1'b1;
        done_flag <= 1'b0;
      end else if (done) begin
        busy      <= 1'b0;
        done_flag <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/mem_sp.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_sp #(
  parameter int DEPTH_LOG = 12,
  parameter int WIDTH     = 16
) (
  input  logic                 clk,
  input  logic                 we,
  input  logic [DEPTH_LOG-1:0] addr,
  input  logic [WIDTH-1:0]     wdata,
  output logic [WIDTH-1:0]     rdata
);

  logic [WIDTH-1:0] mem [2**DEPTH_LOG];

  // Read returns the old word on a write to the same address
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

endmodule

`default_nettype wire

// ==== src/kinpira_pkg.sv ====
`default_nettype none

package kinpira_pkg;

  localparam int DWIDTH    = 16;
  localparam int IMGSIZE   = 12;
  localparam int NETSIZE   = 11;
  localparam int LWIDTH    = 10;
  localparam int FRACBITS  = 8;
  localparam int ACCWIDTH  = 40;
  localparam int WB_AWIDTH = 16;
  localparam int WB_DWIDTH = 32;

  // Address bits 15:14
  localparam logic [1:0] REGION_REG = 2'd0;
  localparam logic [1:0] REGION_IMG = 2'd1;
  localparam logic [1:0] REGION_NET = 2'd2;

  localparam int REG_CTRL       = 0;
  localparam int REG_STATUS     = 1;
  localparam int REG_IN_OFFSET  = 2;
  localparam int REG_OUT_OFFSET = 3;
  localparam int REG_NET_OFFSET = 4;
  localparam int REG_TOTAL_IN   = 5;
  localparam int REG_TOTAL_OUT  = 6;

  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [WB_AWIDTH-1:0] adr;
    logic [WB_DWIDTH-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic                 ack;
    logic [WB_DWIDTH-1:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic [IMGSIZE-1:0] in_offset;
    logic [IMGSIZE-1:0] out_offset;
    logic [NETSIZE-1:0] net_offset;
    logic [LWIDTH-1:0]  total_in;
    logic [LWIDTH-1:0]  total_out;
  } layer_cfg_t;

  typedef struct packed {
    logic               we;
    logic [IMGSIZE-1:0] addr;
    logic [DWIDTH-1:0]  wdata;
  } img_req_t;

  typedef struct packed {
    logic               we;
    logic [NETSIZE-1:0] addr;
    logic [DWIDTH-1:0]  wdata;
  } net_req_t;

endpackage

`default_nettype wire
